//--- Makefile
# Verilator build and run for the memory-bank power controller

TOP = mcu_power_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f $(wildcard source/*.sv bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- bench/mcu_power_assert.sv
// sequencing invariants for the memory-bank power controller
// bound to the top level
`timescale 1ns/1ps

module mcu_power_assert
  import mcu_power_pkg::*;
#(
  parameter int NUM_BANKS = 6
) (
  input logic                 clk_i,
  input logic                 arst_n_i,
  input logic [NUM_BANKS-1:0] bank_switch_no,
  input logic [NUM_BANKS-1:0] bank_iso_no,
  input logic [NUM_BANKS-1:0] bank_retentive_no,
  input logic [NUM_BANKS-1:0] bank_clkgate_en_no,
  input logic                 event_valid_o,
  input bank_idx_t            event_bank_o
);

  // open switch needs isolation and a stopped clock
  a_switch_off_isolated : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (~bank_switch_no & (bank_iso_no | bank_clkgate_en_no)) == '0
  ) else $error("bank switched off without isolation or clock gating");

  // retention only with the clock stopped
  a_retention_gated : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (~bank_retentive_no & bank_clkgate_en_no) == '0
  ) else $error("bank in retention with its clock running");

  a_event_bank_range : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    event_valid_o |-> int'(event_bank_o) < NUM_BANKS
  ) else $error("event reports a bank that does not exist");

endmodule

bind mcu_power_ctrl mcu_power_assert #(
  .NUM_BANKS(NUM_BANKS)
) mcu_power_assert_i (
  .clk_i             (clk_i),
  .arst_n_i          (arst_n_i),
  .bank_switch_no    (bank_switch_no),
  .bank_iso_no       (bank_iso_no),
  .bank_retentive_no (bank_retentive_no),
  .bank_clkgate_en_no(bank_clkgate_en_no),
  .event_valid_o     (event_valid_o),
  .event_bank_o      (event_bank_o)
);

//--- bench/mcu_power_tb.sv
// testbench for the memory-bank power controller
// file-driven commands, switch acknowledge model and result checks
`timescale 1ns/1ps

module mcu_power_tb
  import mcu_power_pkg::*;
();

  localparam int NUM_BANKS   = 6;
  localparam int ACK_TIMEOUT = 20;
  localparam int WAIT_LIMIT  = 200;
  localparam int QUIET_LIMIT = 12;
  localparam int NEVER       = 255;

  logic                 clk_i = 1'b0;
  logic                 arst_n_i;
  logic                 cmd_valid_i;
  bank_idx_t            cmd_bank_i;
  power_op_t            cmd_op_i;
  logic [NUM_BANKS-1:0] bank_switch_ack_ni;
  logic [NUM_BANKS-1:0] bank_switch_no;
  logic [NUM_BANKS-1:0] bank_iso_no;
  logic [NUM_BANKS-1:0] bank_retentive_no;
  logic [NUM_BANKS-1:0] bank_clkgate_en_no;
  logic [NUM_BANKS-1:0] bank_rst_no;
  logic                 cmd_error_o;
  logic                 event_valid_o;
  bank_idx_t            event_bank_o;
  power_result_t        event_result_o;

  int    ack_delay = 1;
  int    ack_cnt [NUM_BANKS] = '{default: 0};
  int    errors;
  int    tests_run;
  int    tests_failed;
  string test_name;

  mcu_power_ctrl #(
    .NUM_BANKS  (NUM_BANKS),
    .ACK_TIMEOUT(ACK_TIMEOUT)
  ) mcu_power_ctrl_i (.*);

  always #20 clk_i = ~clk_i;

  // each acknowledge follows its switch after ack_delay cycles
  always @(negedge clk_i) begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (bank_switch_ack_ni[i] == bank_switch_no[i]) begin
        ack_cnt[i] = 0;
      end else if (ack_delay != NEVER) begin
        ack_cnt[i] = ack_cnt[i] + 1;
        if (ack_cnt[i] >= ack_delay) begin
          bank_switch_ack_ni[i] = bank_switch_no[i];
          ack_cnt[i] = 0;
        end
      end
    end
  end

  task automatic check_value(input string what, input int expected, input int actual);
    assert (expected == actual) else begin
      $display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
      errors++;
    end
  endtask

  // outputs in the order switch, iso, retention, clock gate, reset
  task automatic check_bits(input int bank, input logic [4:0] expected);
    logic [4:0] actual;
    actual = {bank_switch_no[bank], bank_iso_no[bank], bank_retentive_no[bank],
              bank_clkgate_en_no[bank], bank_rst_no[bank]};
    assert (actual == expected) else begin
      $display("[FAIL] %s bank %0d outputs: expected %b, actual %b",
               test_name, bank, expected, actual);
      errors++;
    end
  endtask

  task automatic send_cmd(input int op, input int bank);
    @(negedge clk_i);
    cmd_valid_i = 1'b1;
    cmd_op_i    = power_op_t'(op);
    cmd_bank_i  = bank_idx_t'(bank);
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
  endtask

  task automatic wait_event(output bit seen);
    int cycles;
    cycles = 0;
    while (!event_valid_o && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    seen = event_valid_o;
    if (!seen) begin
      $display("%s: no event within %0d cycles", test_name, WAIT_LIMIT);
      errors++;
    end
  endtask

  task automatic check_idle(input logic [4:0] exp_bits);
    @(negedge clk_i);
    for (int b = 0; b < NUM_BANKS; b++) begin
      check_bits(b, exp_bits);
    end
    check_value("event_valid_o", 0, int'(event_valid_o));
    check_value("cmd_error_o", 0, int'(cmd_error_o));
  endtask

  task automatic check_rejected();
    int cycles;
    cycles = 0;
    while (!cmd_error_o && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!cmd_error_o) begin
      $display("%s: cmd_error_o never pulsed", test_name);
      errors++;
    end
    // error is a single pulse and no event may follow
    for (int n = 0; n < QUIET_LIMIT; n++) begin
      @(negedge clk_i);
      check_value("event_valid_o", 0, int'(event_valid_o));
      check_value("cmd_error_o", 0, int'(cmd_error_o));
    end
  endtask

  task automatic send_pair(input int op, input int bank_a, input int bank_b,
                           input int exp_result, input logic [4:0] exp_bits);
    int cycles;
    int got;
    int seen_mask;
    cycles    = 0;
    got       = 0;
    seen_mask = 0;
    send_cmd(op, bank_a);
    send_cmd(op, bank_b);
    while (got < 2 && cycles < WAIT_LIMIT) begin
      if (event_valid_o) begin
        got++;
        seen_mask = seen_mask | (1 << int'(event_bank_o));
        check_value("event result", exp_result, int'(event_result_o));
      end
      @(negedge clk_i);
      cycles++;
    end
    if (got < 2) begin
      $display("%s: only %0d of 2 events arrived", test_name, got);
      errors++;
    end
    check_value("event bank mask", (1 << bank_a) | (1 << bank_b), seen_mask);
    check_bits(bank_a, exp_bits);
    check_bits(bank_b, exp_bits);
  endtask

  task automatic run_test(input int op, input int bank, input int bank2, input int exp_event,
                          input int exp_bank, input int exp_result, input logic [4:0] exp_bits);
    int errors_before;
    bit seen;
    errors_before = errors;
    if (op == int'(OP_NONE)) begin
      check_idle(exp_bits);
    end else if (exp_event == 0) begin
      send_cmd(op, bank);
      check_rejected();
    end else if (bank2 >= 0) begin
      send_pair(op, bank, bank2, exp_result, exp_bits);
    end else begin
      send_cmd(op, bank);
      wait_event(seen);
      if (seen) begin
        check_value("event bank", exp_bank, int'(event_bank_o));
        check_value("event result", exp_result, int'(event_result_o));
        check_bits(bank, exp_bits);
      end
    end
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed", test_name);
    end
  endtask

  initial begin
    int         fd;
    int         code;
    int         fields;
    string      line;
    string      name;
    int         op;
    int         bank;
    int         bank2;
    int         delay;
    int         exp_event;
    int         exp_bank;
    int         exp_result;
    logic [4:0] exp_bits;
    arst_n_i           = 1'b0;
    cmd_valid_i        = 1'b0;
    cmd_bank_i         = '0;
    cmd_op_i           = OP_NONE;
    bank_switch_ack_ni = '1;
    errors             = 0;
    tests_run          = 0;
    tests_failed       = 0;
    repeat (4) @(negedge clk_i);
    arst_n_i = 1'b1;
    fd = $fopen("bench/power_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open bench/power_tests.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        // skip blank lines and comments
        if (code > 1 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%s %d %d %d %d %d %d %d %b", name, op, bank, bank2,
                           delay, exp_event, exp_bank, exp_result, exp_bits);
          if (fields != 9) begin
            $display("malformed test line: %s", line);
            errors++;
          end else begin
            test_name = name;
            ack_delay = delay;
            run_test(op, bank, bank2, exp_event, exp_bank, exp_result, exp_bits);
          end
        end
      end
      $fclose(fd);
    end
    if (tests_run == 0) begin
      $display("no tests were run");
      errors++;
    end
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- bench/power_tests.txt
# name op bank bank2 ack_delay event exp_bank exp_result outputs
# op 0 none 1 off 2 on 3 retain, bank2 -1 if unused, outputs switch iso ret clkgate rst
# ack_delay 255 means the acknowledge never follows
reset_state        0 0 -1 1   0 0 0 11111
off_bank2          1 2 -1 3   1 2 0 00100
on_bank2           2 2 -1 3   1 2 0 11111
retain_bank4       3 4 -1 2   1 4 0 10001
wake_bank4         2 4 -1 2   1 4 0 11111
timeout_off_bank1  1 1 -1 255 1 1 1 11111
bad_bank7          1 7 -1 3   0 7 0 11111
off_pair_0_3       1 0 3  3   1 0 0 00100
on_when_on_bank5   2 5 -1 2   1 5 0 11111
retain_off_bank0   3 0 -1 2   1 0 0 00100
retain_bank5       3 5 -1 2   1 5 0 10001
off_retained_bank5 1 5 -1 2   1 5 0 00100
on_bank0           2 0 -1 1   1 0 0 11111
timeout_on_bank3   2 3 -1 255 1 3 1 00100
on_bank3           2 3 -1 4   1 3 0 11111
on_bank5           2 5 -1 5   1 5 0 11111

//--- files.f
source/mcu_power_pkg.sv
source/power_cmd_decoder.sv
source/bank_power_seq.sv
source/power_event_collector.sv
source/mcu_power_ctrl.sv
bench/mcu_power_assert.sv
bench/mcu_power_tb.sv

//--- source/bank_power_seq.sv
// power sequencer for one memory bank
// drives switch, isolation, retention, clock gate and reset, all active low
`timescale 1ns/1ps

module bank_power_seq
  import mcu_power_pkg::*;
#(
  parameter int ACK_TIMEOUT = 20
) (
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  logic          start_i,
  input  power_op_t     op_i,
  input  logic          switch_ack_ni,
  output logic          switch_no,
  output logic          iso_no,
  output logic          retentive_no,
  output logic          clkgate_en_no,
  output logic          rst_no,
  output logic          done_o,
  output power_result_t result_o
);

  localparam ack_cnt_t ACK_LAST = ack_cnt_t'(ACK_TIMEOUT - 1);

  bank_state_t   state_q;
  bank_state_t   state_d;
  power_op_t     op_q;
  ack_cnt_t      ack_cnt_q;
  logic          timeout_q;
  logic          timeout_d;
  logic          done_d;
  power_result_t res_d;
  logic          resting;
  logic          waiting;
  logic          ack_expired;

  assign resting     = state_q inside {ST_ON, ST_OFF, ST_RETAINED};
  assign waiting     = state_q inside {ST_WAIT_OFF, ST_WAIT_ON};
  assign ack_expired = ack_cnt_q == ACK_LAST;

  always_comb begin
    state_d   = state_q;
    timeout_d = timeout_q;
    done_d    = 1'b0;
    res_d     = RES_OK;
    if (start_i && resting) begin
      timeout_d = 1'b0;
    end
    case (state_q)
      ST_ON: begin
        if (start_i) begin
          if (op_i == OP_POWER_OFF || op_i == OP_RETAIN) begin
            state_d = ST_CLK_OFF;
          end else if (op_i == OP_POWER_ON) begin
            done_d = 1'b1;
          end
        end
      end
      ST_OFF: begin
        if (start_i) begin
          if (op_i == OP_POWER_ON) begin
            state_d = ST_WAIT_ON;
          end else if (op_i != OP_NONE) begin
            done_d = 1'b1;
          end
        end
      end
      ST_RETAINED: begin
        if (start_i) begin
          case (op_i)
            // bank is already isolated so it goes straight to the switch
            OP_POWER_OFF: state_d = ST_ISO_ON;
            OP_POWER_ON:  state_d = ST_RET_OFF;
            OP_RETAIN:    done_d = 1'b1;
            default:      state_d = ST_RETAINED;
          endcase
        end
      end
      ST_CLK_OFF: state_d = ST_ISO_ON;
      ST_ISO_ON: state_d = (op_q == OP_RETAIN) ? ST_RET_ON : ST_WAIT_OFF;
      ST_WAIT_OFF: begin
        if (!switch_ack_ni) begin
          state_d = ST_OFF;
          done_d  = 1'b1;
        end else if (ack_expired) begin
          // switch never opened so back out through the power-on path
          state_d   = ST_WAIT_ON;
          timeout_d = 1'b1;
        end
      end
      ST_WAIT_ON: begin
        if (switch_ack_ni) begin
          state_d = ST_ISO_OFF;
        end else if (ack_expired) begin
          state_d = ST_OFF;
          done_d  = 1'b1;
          res_d   = RES_TIMEOUT;
        end
      end
      ST_ISO_OFF: state_d = ST_CLK_ON;
      ST_RET_OFF: state_d = ST_CLK_ON;
      ST_CLK_ON: begin
        state_d = ST_ON;
        done_d  = 1'b1;
        res_d   = timeout_q ? RES_TIMEOUT : RES_OK;
      end
      ST_RET_ON: begin
        state_d = ST_RETAINED;
        done_d  = 1'b1;
      end
      default: state_d = ST_ON;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= ST_ON;
      timeout_q <= 1'b0;
      ack_cnt_q <= '0;
      done_o    <= 1'b0;
      result_o  <= RES_OK;
    end else begin
      state_q   <= state_d;
      timeout_q <= timeout_d;
      done_o    <= done_d;
      result_o  <= res_d;
      if (state_d != state_q || !waiting) begin
        ack_cnt_q <= '0;
      end else begin
        ack_cnt_q <= ack_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i && resting) begin
      op_q <= op_i;
    end
  end

  // pad levels per state
  // reset only asserted on a real power-off
  always_comb begin
    switch_no     = 1'b1;
    iso_no        = 1'b1;
    retentive_no  = 1'b1;
    clkgate_en_no = 1'b1;
    rst_no        = 1'b1;
    case (state_q)
      ST_ON: clkgate_en_no = 1'b1;
      ST_CLK_OFF, ST_ISO_OFF, ST_CLK_ON: clkgate_en_no = 1'b0;
      ST_ISO_ON: begin
        clkgate_en_no = 1'b0;
        iso_no        = 1'b0;
        rst_no        = (op_q == OP_RETAIN);
      end
      ST_WAIT_OFF, ST_OFF, ST_WAIT_ON: begin
        switch_no     = (state_q == ST_WAIT_ON);
        clkgate_en_no = 1'b0;
        iso_no        = 1'b0;
        rst_no        = 1'b0;
      end
      ST_RET_ON, ST_RETAINED, ST_RET_OFF: begin
        clkgate_en_no = 1'b0;
        iso_no        = 1'b0;
        retentive_no  = (state_q == ST_RET_OFF);
      end
      default: clkgate_en_no = 1'b1;
    endcase
    if (state_q == ST_ISO_OFF) begin
      rst_no = 1'b0;
    end
  end

endmodule

//--- source/mcu_power_ctrl.sv
// memory-bank power controller top
// command decoder, one power sequencer per bank and the event collector
`timescale 1ns/1ps

module mcu_power_ctrl
  import mcu_power_pkg::*;
#(
  parameter int NUM_BANKS   = 6,
  parameter int ACK_TIMEOUT = 20
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 cmd_valid_i,
  input  bank_idx_t            cmd_bank_i,
  input  power_op_t            cmd_op_i,
  input  logic [NUM_BANKS-1:0] bank_switch_ack_ni,
  output logic [NUM_BANKS-1:0] bank_switch_no,
  output logic [NUM_BANKS-1:0] bank_iso_no,
  output logic [NUM_BANKS-1:0] bank_retentive_no,
  output logic [NUM_BANKS-1:0] bank_clkgate_en_no,
  output logic [NUM_BANKS-1:0] bank_rst_no,
  output logic                 cmd_error_o,
  output logic                 event_valid_o,
  output bank_idx_t            event_bank_o,
  output power_result_t        event_result_o
);

  logic [NUM_BANKS-1:0] bank_start;
  power_op_t            start_op;
  logic [NUM_BANKS-1:0] bank_done;
  logic [NUM_BANKS-1:0] bank_result;

  power_cmd_decoder #(
    .NUM_BANKS(NUM_BANKS)
  ) power_cmd_decoder_i (
    .clk_i,
    .arst_n_i,
    .cmd_valid_i,
    .cmd_bank_i,
    .cmd_op_i,
    .bank_start_o(bank_start),
    .start_op_o  (start_op),
    .cmd_error_o
  );

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
    bank_power_seq #(
      .ACK_TIMEOUT(ACK_TIMEOUT)
    ) bank_power_seq_i (
      .clk_i,
      .arst_n_i,
      .start_i      (bank_start[i]),
      .op_i         (start_op),
      .switch_ack_ni(bank_switch_ack_ni[i]),
      .switch_no    (bank_switch_no[i]),
      .iso_no       (bank_iso_no[i]),
      .retentive_no (bank_retentive_no[i]),
      .clkgate_en_no(bank_clkgate_en_no[i]),
      .rst_no       (bank_rst_no[i]),
      .done_o       (bank_done[i]),
      .result_o     (bank_result[i])
    );
  end

  power_event_collector #(
    .NUM_BANKS(NUM_BANKS)
  ) power_event_collector_i (
    .clk_i,
    .arst_n_i,
    .bank_done_i  (bank_done),
    .bank_result_i(bank_result),
    .event_valid_o,
    .event_bank_o,
    .event_result_o
  );

endmodule

//--- source/mcu_power_pkg.sv
// memory-bank power controller shared definitions
// bank index width, command and result codes, sequencer states

package mcu_power_pkg;

  localparam int BANK_IDX_W = 3;

  typedef logic [BANK_IDX_W-1:0] bank_idx_t;
  typedef logic [7:0]            ack_cnt_t;

  typedef enum logic [1:0] {
    OP_NONE      = 2'd0,
    OP_POWER_OFF = 2'd1,
    OP_POWER_ON  = 2'd2,
    OP_RETAIN    = 2'd3
  } power_op_t;

  typedef enum logic {
    RES_OK      = 1'b0,
    RES_TIMEOUT = 1'b1
  } power_result_t;

  // resting states first, then the three transition paths
  typedef enum logic [3:0] {
    ST_ON, ST_OFF, ST_RETAINED,
    ST_CLK_OFF, ST_ISO_ON, ST_WAIT_OFF,
    ST_WAIT_ON, ST_ISO_OFF, ST_CLK_ON,
    ST_RET_ON, ST_RET_OFF
  } bank_state_t;

endpackage

//--- source/power_cmd_decoder.sv
// power command decoder
// registers one command per strobe into a one-hot bank start or an error pulse
`timescale 1ns/1ps

module power_cmd_decoder
  import mcu_power_pkg::*;
#(
  parameter int NUM_BANKS = 6
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 cmd_valid_i,
  input  bank_idx_t            cmd_bank_i,
  input  power_op_t            cmd_op_i,
  output logic [NUM_BANKS-1:0] bank_start_o,
  output power_op_t            start_op_o,
  output logic                 cmd_error_o
);

  logic                 cmd_take;
  logic                 in_range;
  logic [NUM_BANKS-1:0] start_d;

  // an OP_NONE strobe is not a command
  assign cmd_take = cmd_valid_i && (cmd_op_i != OP_NONE);
  assign in_range = int'(cmd_bank_i) < NUM_BANKS;

  always_comb begin
    start_d = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      start_d[i] = cmd_take && in_range && (cmd_bank_i == bank_idx_t'(i));
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bank_start_o <= '0;
      start_op_o   <= OP_NONE;
      cmd_error_o  <= 1'b0;
    end else begin
      bank_start_o <= start_d;
      cmd_error_o  <= cmd_take && !in_range;
      // op stays put until the next command
      if (cmd_take) begin
        start_op_o <= cmd_op_i;
      end
    end
  end

endmodule

//--- source/power_event_collector.sv
// completion event collector
// keeps one pending flag per bank and emits the lowest pending bank each cycle
`timescale 1ns/1ps

module power_event_collector
  import mcu_power_pkg::*;
#(
  parameter int NUM_BANKS = 6
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic [NUM_BANKS-1:0] bank_done_i,
  input  logic [NUM_BANKS-1:0] bank_result_i,
  output logic                 event_valid_o,
  output bank_idx_t            event_bank_o,
  output power_result_t        event_result_o
);

  logic [NUM_BANKS-1:0] pending_q;
  logic [NUM_BANKS-1:0] result_q;
  logic [NUM_BANKS-1:0] clear;
  logic                 any_pending;
  bank_idx_t            sel;

  assign any_pending = |pending_q;

  // priority encoder, lowest index wins
  always_comb begin
    sel   = '0;
    clear = '0;
    for (int i = NUM_BANKS - 1; i >= 0; i--) begin
      if (pending_q[i]) begin
        sel = bank_idx_t'(i);
      end
    end
    if (any_pending) begin
      clear[sel] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q      <= '0;
      event_valid_o  <= 1'b0;
      event_bank_o   <= '0;
      event_result_o <= RES_OK;
    end else begin
      // a fresh done outranks the clear of the same bank
      pending_q     <= (pending_q & ~clear) | bank_done_i;
      event_valid_o <= any_pending;
      if (any_pending) begin
        event_bank_o   <= sel;
        event_result_o <= power_result_t'(result_q[sel]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (bank_done_i[i]) begin
        result_q[i] <= bank_result_i[i];
      end
    end
  end

endmodule
